// File: verilog/iir_pkg.sv
package iir_pkg;

   // Q1.15 samples, Q2.14 coefficients
   typedef logic signed [15:0] sample_t;
   typedef logic signed [33:0] acc_t;
   typedef logic signed [15:0] coef_t;

   // lowpass biquad, y[n] = b.x - a.y
   localparam coef_t IIR_B0 = 16'sd4096;
   localparam coef_t IIR_B1 = 16'sd8192;
   localparam coef_t IIR_B2 = 16'sd4096;
   localparam coef_t IIR_A1 = -16'sd11469;
   localparam coef_t IIR_A2 = 16'sd3277;

   localparam int IIR_COEF_FRAC = 14;

   // output clamp limits
   localparam acc_t IIR_SAMPLE_MAX = 34'sd32767;
   localparam acc_t IIR_SAMPLE_MIN = -34'sd32768;

   // frame geometry
   localparam int IIR_FRAME_LEN = 32;
   localparam int IIR_ADDR_W = 5;

   // cycles between input strobes
   localparam int IIR_SAMPLE_SPACING = 3;

   // word offsets, from wb_adr_i[5:2]
   localparam logic [3:0] IIR_REG_CTRL = 4'd0;
   localparam logic [3:0] IIR_REG_STATUS = 4'd1;
   localparam logic [3:0] IIR_REG_WADDR = 4'd2;
   localparam logic [3:0] IIR_REG_WDATA = 4'd3;
   localparam logic [3:0] IIR_REG_RADDR = 4'd4;
   localparam logic [3:0] IIR_REG_RDATA = 4'd5;
   localparam logic [3:0] IIR_REG_IRQ_EN = 4'd6;

endpackage

// File: verilog/iir_section_if.sv
interface iir_section_if;

   logic              clr;
   logic              x_stb;
   iir_pkg::sample_t  x;
   iir_pkg::acc_t     ff_sum;
   iir_pkg::acc_t     fb_sum;
   logic              sum_stb;
   logic              y_stb;
   iir_pkg::sample_t  y;

   // frame sequencer
   modport seq (output clr, output x_stb, output x, input y_stb, input y);

   // input history side
   modport ff (input clr, input x_stb, input x, output ff_sum, output sum_stb);

   // output history side
   modport fb (input clr, input sum_stb, input y_stb, input y, output fb_sum);

   // sum, round, clamp
   modport comb (input ff_sum, input fb_sum, input sum_stb, output y_stb, output y);

endinterface

// File: verilog/iir_sample_buffer.sv
module iir_sample_buffer #(
   parameter type sample_type = iir_pkg::sample_t
) (
   input  logic                            wb_clk_i,
   input  logic                            we_i,
   input  logic [iir_pkg::IIR_ADDR_W-1:0]  waddr_i,
   input  sample_type                      wdata_i,
   input  logic [iir_pkg::IIR_ADDR_W-1:0]  raddr_i,
   output sample_type                      rdata_o
);

   sample_type mem [iir_pkg::IIR_FRAME_LEN];

   always_ff @(posedge wb_clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // one cycle read latency
   always_ff @(posedge wb_clk_i) begin
      rdata_o <= mem[raddr_i];
   end

endmodule

// File: verilog/iir_wb_regs.sv
module iir_wb_regs (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic [31:0]                     wb_adr_i,
   input  logic [31:0]                     wb_dat_i,
   input  logic [3:0]                      wb_sel_i,
   input  logic                            wb_we_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_cyc_i,
   output logic [31:0]                     wb_dat_o,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,
   input  logic                            busy_i,
   input  logic                            done_i,
   input  iir_pkg::sample_t                rdata_i,
   output logic                            start_o,
   output logic                            in_we_o,
   output logic [iir_pkg::IIR_ADDR_W-1:0]  in_waddr_o,
   output iir_pkg::sample_t                in_wdata_o,
   output logic [iir_pkg::IIR_ADDR_W-1:0]  out_raddr_o,
   output logic                            int_o
);

   logic [3:0]                      offset;
   logic                            new_req;
   logic                            mapped;
   logic                            wr_en;
   logic [31:0]                     rd_mux;
   logic [iir_pkg::IIR_ADDR_W-1:0]  waddr_q;
   logic [iir_pkg::IIR_ADDR_W-1:0]  raddr_q;
   logic                            irq_en_q;

   assign offset = wb_adr_i[5:2];
   // a strobe held through its ack is not a second request
   assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
   assign mapped = offset <= iir_pkg::IIR_REG_IRQ_EN;
   // all writes are full word, wb_sel_i plays no part
   assign wr_en = new_req & mapped & wb_we_i;

   // input buffer is written on the same edge as the request
   assign in_we_o = wr_en && (offset == iir_pkg::IIR_REG_WDATA);
   assign in_waddr_o = waddr_q;
   assign in_wdata_o = wb_dat_i[15:0];
   assign out_raddr_o = raddr_q;
   assign int_o = done_i & irq_en_q;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         start_o <= 1'b0;
         waddr_q <= '0;
         raddr_q <= '0;
         irq_en_q <= 1'b0;
      end else begin
         wb_ack_o <= new_req & mapped;
         wb_err_o <= new_req & ~mapped;
         start_o <= wr_en && (offset == iir_pkg::IIR_REG_CTRL) && wb_dat_i[0];
         if (wr_en) begin
            case (offset)
               iir_pkg::IIR_REG_WADDR: waddr_q <= wb_dat_i[iir_pkg::IIR_ADDR_W-1:0];
               // auto increment for frame loads
               iir_pkg::IIR_REG_WDATA: waddr_q <= waddr_q + 1'b1;
               iir_pkg::IIR_REG_RADDR: raddr_q <= wb_dat_i[iir_pkg::IIR_ADDR_W-1:0];
               iir_pkg::IIR_REG_IRQ_EN: irq_en_q <= wb_dat_i[0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (offset)
         iir_pkg::IIR_REG_STATUS: rd_mux = {30'b0, done_i, busy_i};
         iir_pkg::IIR_REG_WADDR: rd_mux = {27'b0, waddr_q};
         iir_pkg::IIR_REG_RADDR: rd_mux = {27'b0, raddr_q};
         iir_pkg::IIR_REG_RDATA: rd_mux = {{16{rdata_i[15]}}, rdata_i};
         iir_pkg::IIR_REG_IRQ_EN: rd_mux = {31'b0, irq_en_q};
         default: rd_mux = 32'b0;
      endcase
   end

   // sampled with the request, presented with the ack
   always_ff @(posedge wb_clk_i) begin
      if (new_req) begin
         wb_dat_o <= rd_mux;
      end
   end

endmodule

// File: verilog/iir_frame_sequencer.sv
module iir_frame_sequencer (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            start_i,
   output logic                            busy_o,
   output logic                            done_o,
   output logic [iir_pkg::IIR_ADDR_W-1:0]  in_raddr_o,
   input  iir_pkg::sample_t                in_rdata_i,
   output logic                            out_we_o,
   output logic [iir_pkg::IIR_ADDR_W-1:0]  out_waddr_o,
   output iir_pkg::sample_t                out_wdata_o,
   iir_section_if.seq                      sec
);

   logic                                          go;
   logic                                          issue;
   logic                                          rd_pend;
   logic [iir_pkg::IIR_ADDR_W:0]                  issue_cnt;
   logic [$clog2(iir_pkg::IIR_SAMPLE_SPACING)-1:0] space_cnt;
   logic [iir_pkg::IIR_ADDR_W:0]                  out_cnt;

   // start is dropped while a frame runs
   assign go = start_i & ~busy_o;
   assign sec.clr = go;

   assign issue = busy_o && (space_cnt == '0) && (issue_cnt < iir_pkg::IIR_FRAME_LEN);
   assign in_raddr_o = issue_cnt[iir_pkg::IIR_ADDR_W-1:0];

   // buffer data lands one cycle after the read
   assign sec.x_stb = rd_pend;
   assign sec.x = in_rdata_i;

   assign out_we_o = sec.y_stb;
   assign out_waddr_o = out_cnt[iir_pkg::IIR_ADDR_W-1:0];
   assign out_wdata_o = sec.y;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         busy_o <= 1'b0;
         done_o <= 1'b0;
         rd_pend <= 1'b0;
         issue_cnt <= '0;
         space_cnt <= '0;
         out_cnt <= '0;
      end else begin
         rd_pend <= issue;
         if (go) begin
            busy_o <= 1'b1;
            done_o <= 1'b0;
            issue_cnt <= '0;
            space_cnt <= '0;
            out_cnt <= '0;
         end else begin
            if (issue) begin
               issue_cnt <= issue_cnt + 1'b1;
               space_cnt <= $bits(space_cnt)'(iir_pkg::IIR_SAMPLE_SPACING - 1);
            end else if (space_cnt != '0) begin
               space_cnt <= space_cnt - 1'b1;
            end
            if (sec.y_stb) begin
               out_cnt <= out_cnt + 1'b1;
               // last result written, frame complete
               if (out_cnt == iir_pkg::IIR_FRAME_LEN - 1) begin
                  busy_o <= 1'b0;
                  done_o <= 1'b1;
               end
            end
         end
      end
   end

endmodule

// File: verilog/iir_feedforward.sv
module iir_feedforward (
   input  logic      wb_clk_i,
   input  logic      wb_rst_i,
   iir_section_if.ff sec
);

   iir_pkg::sample_t x1;
   iir_pkg::sample_t x2;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         sec.sum_stb <= 1'b0;
      end else begin
         sec.sum_stb <= sec.x_stb;
      end
   end

   // taps and partial sum
   always_ff @(posedge wb_clk_i) begin
      if (sec.clr) begin
         x1 <= '0;
         x2 <= '0;
      end else if (sec.x_stb) begin
         sec.ff_sum <= iir_pkg::IIR_B0 * sec.x
                     + iir_pkg::IIR_B1 * x1
                     + iir_pkg::IIR_B2 * x2;
         x1 <= sec.x;
         x2 <= x1;
      end
   end

endmodule

// File: verilog/iir_feedback.sv
module iir_feedback (
   input  logic      wb_clk_i,
   input  logic      wb_rst_i,
   iir_section_if.fb sec
);

   iir_pkg::sample_t y1;
   iir_pkg::sample_t y2;
   logic             pend;

   always_ff @(posedge wb_clk_i) begin
      if (sec.clr) begin
         y1 <= '0;
         y2 <= '0;
      end else if (sec.y_stb) begin
         y1 <= sec.y;
         y2 <= y1;
      end
   end

   // history moved, sum owed
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         pend <= 1'b0;
      end else if (sec.clr || sec.y_stb) begin
         pend <= 1'b1;
      end else if (!sec.sum_stb) begin
         pend <= 1'b0;
      end
   end

   // held still while the combiner samples it
   always_ff @(posedge wb_clk_i) begin
      if (pend && !sec.sum_stb) begin
         sec.fb_sum <= -(iir_pkg::IIR_A1 * y1) - (iir_pkg::IIR_A2 * y2);
      end
   end

endmodule

// File: verilog/iir_combiner.sv
module iir_combiner (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   iir_section_if.comb sec
);

   iir_pkg::acc_t    total;
   iir_pkg::acc_t    scaled;
   iir_pkg::sample_t clamped;

   always_comb begin
      // round half up before dropping the coefficient fraction
      total = sec.ff_sum + sec.fb_sum + iir_pkg::acc_t'(2 ** (iir_pkg::IIR_COEF_FRAC - 1));
      scaled = total >>> iir_pkg::IIR_COEF_FRAC;
      if (scaled > iir_pkg::IIR_SAMPLE_MAX) begin
         clamped = 16'sh7fff;
      end else if (scaled < iir_pkg::IIR_SAMPLE_MIN) begin
         clamped = 16'sh8000;
      end else begin
         clamped = iir_pkg::sample_t'(scaled);
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         sec.y_stb <= 1'b0;
      end else begin
         sec.y_stb <= sec.sum_stb;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (sec.sum_stb) begin
         sec.y <= clamped;
      end
   end

endmodule

// File: verilog/iir_top.sv
module iir_top (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic [3:0]  wb_sel_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic        int_o
);

   logic                            start;
   logic                            busy;
   logic                            done;
   logic                            in_we;
   logic [iir_pkg::IIR_ADDR_W-1:0]  in_waddr;
   iir_pkg::sample_t                in_wdata;
   logic [iir_pkg::IIR_ADDR_W-1:0]  in_raddr;
   iir_pkg::sample_t                in_rdata;
   logic                            out_we;
   logic [iir_pkg::IIR_ADDR_W-1:0]  out_waddr;
   iir_pkg::sample_t                out_wdata;
   logic [iir_pkg::IIR_ADDR_W-1:0]  out_raddr;
   iir_pkg::sample_t                out_rdata;

   iir_section_if sec ();

   iir_wb_regs u_regs (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_stb_i    (wb_stb_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .wb_err_o    (wb_err_o),
      .busy_i      (busy),
      .done_i      (done),
      .rdata_i     (out_rdata),
      .start_o     (start),
      .in_we_o     (in_we),
      .in_waddr_o  (in_waddr),
      .in_wdata_o  (in_wdata),
      .out_raddr_o (out_raddr),
      .int_o       (int_o)
   );

   // frame in, written from the bus
   iir_sample_buffer #(.sample_type(iir_pkg::sample_t)) u_in_buf (
      .wb_clk_i (wb_clk_i),
      .we_i     (in_we),
      .waddr_i  (in_waddr),
      .wdata_i  (in_wdata),
      .raddr_i  (in_raddr),
      .rdata_o  (in_rdata)
   );

   // results out, read from the bus
   iir_sample_buffer #(.sample_type(iir_pkg::sample_t)) u_out_buf (
      .wb_clk_i (wb_clk_i),
      .we_i     (out_we),
      .waddr_i  (out_waddr),
      .wdata_i  (out_wdata),
      .raddr_i  (out_raddr),
      .rdata_o  (out_rdata)
   );

   iir_frame_sequencer u_seq (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .start_i     (start),
      .busy_o      (busy),
      .done_o      (done),
      .in_raddr_o  (in_raddr),
      .in_rdata_i  (in_rdata),
      .out_we_o    (out_we),
      .out_waddr_o (out_waddr),
      .out_wdata_o (out_wdata),
      .sec         (sec)
   );

   iir_feedforward u_ff (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .sec      (sec)
   );

   iir_feedback u_fb (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .sec      (sec)
   );

   iir_combiner u_comb (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .sec      (sec)
   );

endmodule

// File: sim/tb_iir_top.sv
module tb_iir_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BUS_TIMEOUT = 20;
   localparam int DONE_TIMEOUT = 500;
   localparam int NUM_ROWS = 6;
   localparam int N = iir_pkg::IIR_FRAME_LEN;

   typedef enum {PAT_IMPULSE, PAT_STEP, PAT_FULL_STEP, PAT_ALT, PAT_RANDOM} pattern_t;

   typedef struct {
      string    name;
      pattern_t kind;
      int       amp;
      bit       irq_en;
   } row_t;

   logic             wb_clk_i;
   logic             wb_rst_i;
   logic [31:0]      wb_adr_i;
   logic [31:0]      wb_dat_i;
   logic [3:0]       wb_sel_i;
   logic             wb_we_i;
   logic             wb_stb_i;
   logic             wb_cyc_i;
   logic [31:0]      wb_dat_o;
   logic             wb_ack_o;
   logic             wb_err_o;
   logic             int_o;

   row_t             table_rows [NUM_ROWS];
   iir_pkg::sample_t x_frame [N];
   iir_pkg::sample_t y_model [N];
   iir_pkg::sample_t y_dut [N];
   iir_pkg::sample_t y_prev [N];
   string            cur_test;
   int               cycle_cnt = 0;
   int               check_cnt = 0;
   int               err_cnt = 0;
   int               test_errs = 0;
   int               test_cnt = 0;
   int               bad_tests = 0;

   iir_top u_dut (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .int_o    (int_o)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #2 wb_clk_i = ~wb_clk_i;
   end

   always @(posedge wb_clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic load_table();
      table_rows[0] = '{"impulse", PAT_IMPULSE, 16384, 1'b1};
      table_rows[1] = '{"step", PAT_STEP, 12000, 1'b0};
      table_rows[2] = '{"full-scale step up", PAT_FULL_STEP, 32767, 1'b1};
      table_rows[3] = '{"full-scale step down", PAT_FULL_STEP, -32768, 1'b0};
      table_rows[4] = '{"alternating", PAT_ALT, 32767, 1'b1};
      // random stays last because the history tests rerun it
      table_rows[5] = '{"random", PAT_RANDOM, 20000, 1'b0};
   endtask

   task automatic abort_run(input string what);
      $display("ERROR: %s", what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      test_cnt++;
      if (test_errs == 0) begin
         $display("ok    %s", cur_test);
      end else begin
         $display("bad   %s (%0d errors)", cur_test, test_errs);
         bad_tests++;
      end
   endtask

   task automatic check_sample(input string what, input iir_pkg::sample_t exp,
                               input iir_pkg::sample_t act);
      check_cnt++;
      if (act !== exp) begin
         $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
         err_cnt++;
         test_errs++;
      end
   endtask

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      if (act !== exp) begin
         $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
         err_cnt++;
         test_errs++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp) begin
         $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
         err_cnt++;
         test_errs++;
      end
   endtask

   // one Wishbone cycle with outputs sampled on the falling edge
   task automatic bus_cycle(input logic we, input logic [3:0] offset, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic ack, output logic err);
      int n;
      @(posedge wb_clk_i);
      wb_adr_i <= {26'b0, offset, 2'b00};
      wb_dat_i <= wdata;
      wb_we_i <= we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      n = 0;
      ack = 1'b0;
      err = 1'b0;
      while (!ack && !err) begin
         @(negedge wb_clk_i);
         ack = wb_ack_o;
         err = wb_err_o;
         rdata = wb_dat_o;
         n++;
         if (!ack && !err && n >= BUS_TIMEOUT) begin
            abort_run("the bus gave neither ack nor err within 20 cycles");
         end
      end
      @(posedge wb_clk_i);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i <= 1'b0;
   endtask

   task automatic bus_write(input logic [3:0] offset, input logic [31:0] data);
      logic [31:0] unused;
      logic        ack;
      logic        err;
      bus_cycle(1'b1, offset, data, unused, ack, err);
      check_flag("write err", 1'b0, err);
   endtask

   task automatic bus_read(input logic [3:0] offset, output logic [31:0] data);
      logic ack;
      logic err;
      bus_cycle(1'b0, offset, 32'b0, data, ack, err);
      check_flag("read err", 1'b0, err);
   endtask

   function automatic void make_frame(input row_t row);
      int r;
      for (int i = 0; i < N; i++) begin
         case (row.kind)
            PAT_IMPULSE: x_frame[i] = (i == 0) ? iir_pkg::sample_t'(row.amp) : '0;
            PAT_STEP: x_frame[i] = iir_pkg::sample_t'(row.amp);
            PAT_FULL_STEP: x_frame[i] = (row.amp < 0) ? 16'sh8000 : 16'sh7fff;
            PAT_ALT: x_frame[i] = iir_pkg::sample_t'((i % 2 == 0) ? row.amp : -row.amp);
            default: begin
               r = int'($urandom_range(2 * row.amp, 0)) - row.amp;
               x_frame[i] = iir_pkg::sample_t'(r);
            end
         endcase
      end
   endfunction

   // b = 0.25 0.5 0.25 and a = -0.7 0.2 in Q2.14
   function automatic void model_frame();
      longint x1;
      longint x2;
      longint y1;
      longint y2;
      longint acc;
      x1 = 0;
      x2 = 0;
      y1 = 0;
      y2 = 0;
      for (int n = 0; n < N; n++) begin
         acc = 4096 * longint'(x_frame[n]) + 8192 * x1 + 4096 * x2 + 11469 * y1 - 3277 * y2;
         acc = (acc + 8192) >>> 14;
         if (acc > 32767) begin
            acc = 32767;
         end else if (acc < -32768) begin
            acc = -32768;
         end
         y_model[n] = iir_pkg::sample_t'(acc);
         x2 = x1;
         x1 = x_frame[n];
         y2 = y1;
         y1 = acc;
      end
   endfunction

   task automatic load_frame();
      bus_write(iir_pkg::IIR_REG_WADDR, 32'd0);
      for (int i = 0; i < N; i++) begin
         bus_write(iir_pkg::IIR_REG_WDATA, {{16{x_frame[i][15]}}, x_frame[i]});
      end
   endtask

   task automatic run_frame(input bit irq_en, input bit restart);
      logic [31:0] rd;
      int          t0;
      bus_write(iir_pkg::IIR_REG_IRQ_EN, {31'b0, irq_en});
      bus_write(iir_pkg::IIR_REG_CTRL, 32'd1);
      bus_read(iir_pkg::IIR_REG_STATUS, rd);
      check_flag("busy after start", 1'b1, rd[0]);
      // done is low while the frame runs
      @(negedge wb_clk_i);
      check_flag("int_o while busy", 1'b0, int_o);
      if (restart) begin
         bus_write(iir_pkg::IIR_REG_CTRL, 32'd1);
      end
      t0 = cycle_cnt;
      rd = '0;
      while (!rd[1]) begin
         bus_read(iir_pkg::IIR_REG_STATUS, rd);
         if (!rd[1] && (cycle_cnt - t0 > DONE_TIMEOUT)) begin
            abort_run("done was not set within 500 cycles of start");
         end
      end
      check_flag("busy at done", 1'b0, rd[0]);
      @(negedge wb_clk_i);
      check_flag("int_o at done", irq_en, int_o);
      for (int i = 0; i < N; i++) begin
         bus_write(iir_pkg::IIR_REG_RADDR, i);
         bus_read(iir_pkg::IIR_REG_RDATA, rd);
         y_dut[i] = rd[15:0];
         check_word($sformatf("y[%0d]", i), {{16{y_model[i][15]}}, y_model[i]}, rd);
      end
   endtask

   task automatic register_test();
      logic [31:0] rd;
      logic        ack;
      logic        err;
      start_test("register access");
      bus_read(iir_pkg::IIR_REG_STATUS, rd);
      check_word("status after reset", 32'd0, rd);
      bus_write(iir_pkg::IIR_REG_WADDR, 32'd5);
      bus_read(iir_pkg::IIR_REG_WADDR, rd);
      check_word("waddr", 32'd5, rd);
      bus_write(iir_pkg::IIR_REG_WDATA, 32'h0000_1234);
      bus_write(iir_pkg::IIR_REG_WDATA, 32'h0000_8765);
      bus_read(iir_pkg::IIR_REG_WADDR, rd);
      check_word("waddr advance", 32'd7, rd);
      bus_write(iir_pkg::IIR_REG_RADDR, 32'd17);
      bus_read(iir_pkg::IIR_REG_RADDR, rd);
      check_word("raddr", 32'd17, rd);
      bus_write(iir_pkg::IIR_REG_IRQ_EN, 32'd1);
      bus_read(iir_pkg::IIR_REG_IRQ_EN, rd);
      check_word("irq_en set", 32'd1, rd);
      bus_write(iir_pkg::IIR_REG_IRQ_EN, 32'd0);
      bus_read(iir_pkg::IIR_REG_IRQ_EN, rd);
      check_word("irq_en clear", 32'd0, rd);
      bus_read(iir_pkg::IIR_REG_CTRL, rd);
      check_word("ctrl", 32'd0, rd);
      // unmapped offsets give err on read and write
      bus_cycle(1'b0, 4'd9, 32'd0, rd, ack, err);
      check_flag("offset 9 read err", 1'b1, err);
      check_flag("offset 9 read ack", 1'b0, ack);
      // offset 10 shares its low address bits with WADDR
      bus_cycle(1'b1, 4'd10, 32'h1f, rd, ack, err);
      check_flag("offset 10 write err", 1'b1, err);
      check_flag("offset 10 write ack", 1'b0, ack);
      bus_read(iir_pkg::IIR_REG_WADDR, rd);
      check_word("waddr after offset 10", 32'd7, rd);
      finish_test();
   endtask

   initial begin
      void'($urandom(32'h7f89_003e));
      wb_rst_i = 1'b1;
      wb_adr_i = 32'b0;
      wb_dat_i = 32'b0;
      wb_sel_i = 4'hf;
      wb_we_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      load_table();
      repeat (2) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;

      register_test();

      for (int r = 0; r < NUM_ROWS; r++) begin
         start_test(table_rows[r].name);
         make_frame(table_rows[r]);
         model_frame();
         load_frame();
         run_frame(table_rows[r].irq_en, 1'b0);
         finish_test();
      end

      // same input buffer again so history must start from zero
      start_test("history cleared");
      for (int i = 0; i < N; i++) begin
         y_prev[i] = y_dut[i];
      end
      run_frame(1'b1, 1'b0);
      for (int i = 0; i < N; i++) begin
         check_sample($sformatf("rerun y[%0d]", i), y_prev[i], y_dut[i]);
      end
      finish_test();

      start_test("start while busy");
      run_frame(1'b0, 1'b1);
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, bad_tests, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: sim.f
verilog/iir_pkg.sv
verilog/iir_section_if.sv
verilog/iir_sample_buffer.sv
verilog/iir_wb_regs.sv
verilog/iir_frame_sequencer.sv
verilog/iir_feedforward.sv
verilog/iir_feedback.sv
verilog/iir_combiner.sv
verilog/iir_top.sv
sim/tb_iir_top.sv

// File: Bender.yml
package:
  name: iir_filter

sources:
  - verilog/iir_pkg.sv
  - verilog/iir_section_if.sv
  - verilog/iir_sample_buffer.sv
  - verilog/iir_wb_regs.sv
  - verilog/iir_frame_sequencer.sv
  - verilog/iir_feedforward.sv
  - verilog/iir_feedback.sv
  - verilog/iir_combiner.sv
  - verilog/iir_top.sv
  - target: simulation
    files:
      - sim/tb_iir_top.sv
